// File: rtl/alu_issue_queue.sv
`default_nettype none

module alu_issue_queue #(
    parameter int IQ_SIZE  = 4,
    parameter int AGE_BITS = 3
) (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             issue_en_i,
    input  logic                             flush_i,
    input  logic                             dispatch_valid_i,
    input  iq_pkg::alu_op_e                  dispatch_op_i,
    input  logic [iq_pkg::TAG_W-1:0]         dispatch_tag_i,
    input  logic [iq_pkg::XLEN-1:0]          src_a_i,
    input  logic [iq_pkg::XLEN-1:0]          src_b_i,
    input  logic                             src_a_rdy_i,
    input  logic                             src_b_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0]         src_a_tag_i,
    input  logic [iq_pkg::TAG_W-1:0]         src_b_tag_i,
    input  logic                             cdb_valid_i,
    input  logic [iq_pkg::TAG_W-1:0]         cdb_tag_i,
    input  logic [iq_pkg::XLEN-1:0]          cdb_data_i,
    input  logic                             result_ready_i,
    output logic                             dispatch_ready_o,
    output logic                             result_valid_o,
    output logic [iq_pkg::TAG_W-1:0]         result_tag_o,
    output logic [iq_pkg::XLEN-1:0]          result_data_o,
    output logic [$clog2(IQ_SIZE+1)-1:0]     occupancy_o,
    output logic                             issue_fire_o
);
    import iq_pkg::*;

    localparam int IDX_W = $clog2(IQ_SIZE);
    localparam int OCC_W = $clog2(IQ_SIZE + 1);

    logic [IQ_SIZE-1:0] busy, ready, free, fill, grant, clear;
    logic               grant_valid, accept, issue_fire, fwd_valid;
    logic [IDX_W-1:0]   grant_idx;
    alu_op_e            ent_op  [IQ_SIZE];
    logic [TAG_W-1:0]   ent_tag [IQ_SIZE];
    logic [XLEN-1:0]    ent_opa [IQ_SIZE];
    logic [XLEN-1:0]    ent_opb [IQ_SIZE];
    logic [XLEN-1:0]    alu_res;
    logic               res_valid_q;
    logic [TAG_W-1:0]   res_tag_q;
    logic [XLEN-1:0]    res_data_q;

    // ----------------------------------------------------------------------
    // allocation and issue control
    // ----------------------------------------------------------------------
    assign free             = ~busy;
    assign dispatch_ready_o = |free;
    assign accept           = dispatch_valid_i & dispatch_ready_o & ~flush_i;
    // lowest free slot
    assign fill             = accept ? (free & (~free + 1'b1)) : '0;
    assign issue_fire       = issue_en_i & grant_valid & ~flush_i
                              & (~res_valid_q | result_ready_i);
    assign clear            = issue_fire ? grant : '0;
    // drained result doubles as the second wakeup bus
    assign fwd_valid        = res_valid_q & result_ready_i;
    assign occupancy_o      = OCC_W'($countones(busy));
    assign issue_fire_o     = issue_fire;

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk(clk), .rst_i(rst_i), .flush_i(flush_i), .fill_i(fill[i]), .clear_i(clear[i]),
            .op_i(dispatch_op_i), .tag_i(dispatch_tag_i),
            .src_a_i(src_a_i), .src_b_i(src_b_i),
            .src_a_rdy_i(src_a_rdy_i), .src_b_rdy_i(src_b_rdy_i),
            .src_a_tag_i(src_a_tag_i), .src_b_tag_i(src_b_tag_i),
            .cdb_valid_i(cdb_valid_i), .cdb_tag_i(cdb_tag_i), .cdb_data_i(cdb_data_i),
            .fwd_valid_i(fwd_valid), .fwd_tag_i(res_tag_q), .fwd_data_i(res_data_q),
            .busy_o(busy[i]), .ready_o(ready[i]), .op_o(ent_op[i]), .tag_o(ent_tag[i]),
            .opa_o(ent_opa[i]), .opb_o(ent_opb[i])
        );
    end

    iq_age_select #(.IQ_SIZE(IQ_SIZE), .AGE_BITS(AGE_BITS)) u_age_select (
        .clk(clk), .rst_i(rst_i), .fill_i(fill), .ready_i(ready),
        .grant_o(grant), .grant_valid_o(grant_valid)
    );

    // ----------------------------------------------------------------------
    // execute and result stage
    // ----------------------------------------------------------------------
    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (grant[i]) begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    int_alu u_alu (
        .op_i(ent_op[grant_idx]), .a_i(ent_opa[grant_idx]), .b_i(ent_opb[grant_idx]),
        .res_o(alu_res)
    );

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            res_valid_q <= 1'b0;
        end else if (issue_fire) begin
            res_valid_q <= 1'b1;
        end else if (result_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    // held while the consumer stalls
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res_tag_q  <= ent_tag[grant_idx];
            res_data_q <= alu_res;
        end
    end

    assign result_valid_o = res_valid_q;
    assign result_tag_o   = res_tag_q;
    assign result_data_o  = res_data_q;

endmodule

`default_nettype wire

// File: rtl/alu_issue_top.sv
`default_nettype none

module alu_issue_top #(
    parameter int IQ_SIZE  = 4,
    parameter int AGE_BITS = 3
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      dispatch_valid_i,
    input  iq_pkg::alu_op_e           dispatch_op_i,
    input  logic [iq_pkg::TAG_W-1:0]  dispatch_tag_i,
    input  logic [iq_pkg::XLEN-1:0]   src_a_i,
    input  logic [iq_pkg::XLEN-1:0]   src_b_i,
    input  logic                      src_a_rdy_i,
    input  logic                      src_b_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0]  src_a_tag_i,
    input  logic [iq_pkg::TAG_W-1:0]  src_b_tag_i,
    output logic                      dispatch_ready_o,
    input  logic                      cdb_valid_i,
    input  logic [iq_pkg::TAG_W-1:0]  cdb_tag_i,
    input  logic [iq_pkg::XLEN-1:0]   cdb_data_i,
    output logic                      result_valid_o,
    output logic [iq_pkg::TAG_W-1:0]  result_tag_o,
    output logic [iq_pkg::XLEN-1:0]   result_data_o,
    input  logic                      result_ready_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [iq_pkg::APB_AW-1:0] paddr_i,
    input  logic [iq_pkg::APB_DW-1:0] pwdata_i,
    output logic [iq_pkg::APB_DW-1:0] prdata_o
);

    logic                         issue_en;
    logic                         flush;
    logic                         issue_fire;
    logic [$clog2(IQ_SIZE+1)-1:0] occupancy;

    alu_issue_queue #(.IQ_SIZE(IQ_SIZE), .AGE_BITS(AGE_BITS)) u_queue (
        .clk(clk), .rst_i(rst_i), .issue_en_i(issue_en), .flush_i(flush),
        .dispatch_valid_i(dispatch_valid_i), .dispatch_op_i(dispatch_op_i),
        .dispatch_tag_i(dispatch_tag_i), .src_a_i(src_a_i), .src_b_i(src_b_i),
        .src_a_rdy_i(src_a_rdy_i), .src_b_rdy_i(src_b_rdy_i),
        .src_a_tag_i(src_a_tag_i), .src_b_tag_i(src_b_tag_i),
        .cdb_valid_i(cdb_valid_i), .cdb_tag_i(cdb_tag_i), .cdb_data_i(cdb_data_i),
        .result_ready_i(result_ready_i), .dispatch_ready_o(dispatch_ready_o),
        .result_valid_o(result_valid_o), .result_tag_o(result_tag_o),
        .result_data_o(result_data_o), .occupancy_o(occupancy), .issue_fire_o(issue_fire)
    );

    iq_csr_apb #(.IQ_SIZE(IQ_SIZE)) u_csr (
        .clk(clk), .rst_i(rst_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .occupancy_i(occupancy), .issue_fire_i(issue_fire), .prdata_o(prdata_o),
        .issue_en_o(issue_en), .flush_o(flush)
    );

endmodule

`default_nettype wire

// File: rtl/int_alu.sv
`default_nettype none

module int_alu (
    input  iq_pkg::alu_op_e         op_i,
    input  logic [iq_pkg::XLEN-1:0] a_i,
    input  logic [iq_pkg::XLEN-1:0] b_i,
    output logic [iq_pkg::XLEN-1:0] res_o
);
    import iq_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt;

    // only the low bits of b set the shift distance
    assign shamt = b_i[SHAMT_W-1:0];
    assign lt    = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                res_o = a_i + b_i;
            end
            ALU_SUB: begin
                res_o = a_i - b_i;
            end
            ALU_AND: begin
                res_o = a_i & b_i;
            end
            ALU_OR: begin
                res_o = a_i | b_i;
            end
            ALU_XOR: begin
                res_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                res_o = a_i << shamt;
            end
            ALU_SRL: begin
                res_o = a_i >> shamt;
            end
            ALU_SLT: begin
                res_o = {{(XLEN-1){1'b0}}, lt};
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/iq_age_select.sv
`default_nettype none

module iq_age_select #(
    parameter int IQ_SIZE  = 4,
    parameter int AGE_BITS = 3
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic [IQ_SIZE-1:0] fill_i,
    input  logic [IQ_SIZE-1:0] ready_i,
    output logic [IQ_SIZE-1:0] grant_o,
    output logic               grant_valid_o
);

    logic [AGE_BITS-1:0] age_q [IQ_SIZE];
    logic [AGE_BITS-1:0] best_age;
    logic                found;

    // ----------------------------------------------------------------------
    // age counters
    // ----------------------------------------------------------------------
    // restart on fill, stick at the top value
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (rst_i || fill_i[i]) begin
                age_q[i] <= '0;
            end else if (age_q[i] != {AGE_BITS{1'b1}}) begin
                age_q[i] <= age_q[i] + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // oldest ready pick
    // ----------------------------------------------------------------------
    // strict compare keeps the lower index on a tie
    always_comb begin
        grant_o  = '0;
        found    = 1'b0;
        best_age = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (ready_i[i] && (!found || (age_q[i] > best_age))) begin
                grant_o    = '0;
                grant_o[i] = 1'b1;
                found      = 1'b1;
                best_age   = age_q[i];
            end
        end
    end

    assign grant_valid_o = found;

endmodule

`default_nettype wire

// File: rtl/iq_csr_apb.sv
`default_nettype none

module iq_csr_apb #(
    parameter int IQ_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [iq_pkg::APB_AW-1:0]     paddr_i,
    input  logic [iq_pkg::APB_DW-1:0]     pwdata_i,
    input  logic [$clog2(IQ_SIZE+1)-1:0]  occupancy_i,
    input  logic                          issue_fire_i,
    output logic [iq_pkg::APB_DW-1:0]     prdata_o,
    output logic                          issue_en_o,
    output logic                          flush_o
);
    import iq_pkg::*;

    localparam int OCC_W = $clog2(IQ_SIZE + 1);
    localparam int CNT_W = 16;

    logic             wr_en;
    logic             issue_en_q;
    logic             flush_q;
    logic [CNT_W-1:0] issued_q;

    // zero wait states, write lands at the access edge
    assign wr_en = psel_i & penable_i & pwrite_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_en_q <= 1'b0;
            flush_q    <= 1'b0;
            issued_q   <= '0;
        end else begin
            // flush is a single cycle pulse
            flush_q <= wr_en && (paddr_i == CSR_CTRL) && pwdata_i[1];
            if (wr_en && (paddr_i == CSR_CTRL)) begin
                issue_en_q <= pwdata_i[0];
            end
            if (wr_en && (paddr_i == CSR_ISSUED)) begin
                issued_q <= '0;
            end else if (issue_fire_i) begin
                issued_q <= issued_q + 1'b1;
            end
        end
    end

    // read mux
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                CSR_CTRL:   prdata_o[0]         = issue_en_q;
                CSR_STATUS: prdata_o[OCC_W-1:0] = occupancy_i;
                CSR_ISSUED: prdata_o[CNT_W-1:0] = issued_q;
                default:    prdata_o            = '0;
            endcase
        end
    end

    assign issue_en_o = issue_en_q;
    assign flush_o    = flush_q;

endmodule

`default_nettype wire

// File: rtl/iq_entry.sv
`default_nettype none

module iq_entry (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     flush_i,
    input  logic                     fill_i,
    input  logic                     clear_i,
    input  iq_pkg::alu_op_e          op_i,
    input  logic [iq_pkg::TAG_W-1:0] tag_i,
    input  logic [iq_pkg::XLEN-1:0]  src_a_i,
    input  logic [iq_pkg::XLEN-1:0]  src_b_i,
    input  logic                     src_a_rdy_i,
    input  logic                     src_b_rdy_i,
    input  logic [iq_pkg::TAG_W-1:0] src_a_tag_i,
    input  logic [iq_pkg::TAG_W-1:0] src_b_tag_i,
    input  logic                     cdb_valid_i,
    input  logic [iq_pkg::TAG_W-1:0] cdb_tag_i,
    input  logic [iq_pkg::XLEN-1:0]  cdb_data_i,
    input  logic                     fwd_valid_i,
    input  logic [iq_pkg::TAG_W-1:0] fwd_tag_i,
    input  logic [iq_pkg::XLEN-1:0]  fwd_data_i,
    output logic                     busy_o,
    output logic                     ready_o,
    output iq_pkg::alu_op_e          op_o,
    output logic [iq_pkg::TAG_W-1:0] tag_o,
    output logic [iq_pkg::XLEN-1:0]  opa_o,
    output logic [iq_pkg::XLEN-1:0]  opb_o
);
    import iq_pkg::*;

    logic             busy_q;
    alu_op_e          op_q;
    logic [TAG_W-1:0] tag_q;
    logic             a_rdy_q;
    logic             b_rdy_q;
    logic [TAG_W-1:0] a_tag_q;
    logic [TAG_W-1:0] b_tag_q;
    logic [XLEN-1:0]  opa_q;
    logic [XLEN-1:0]  opb_q;
    // {ready, value} after this cycle's broadcasts
    logic [XLEN:0]    a_next;
    logic [XLEN:0]    b_next;

    // pending source picks up data from cdb first, then the own result bus
    function automatic logic [XLEN:0] wake(input logic             rdy,
                                           input logic [TAG_W-1:0] src_tag,
                                           input logic [XLEN-1:0]  val);
        logic [XLEN:0] res;
        res = {rdy, val};
        if (!rdy && cdb_valid_i && (cdb_tag_i == src_tag)) begin
            res = {1'b1, cdb_data_i};
        end else if (!rdy && fwd_valid_i && (fwd_tag_i == src_tag)) begin
            res = {1'b1, fwd_data_i};
        end
        return res;
    endfunction

    // on fill the dispatch fields are checked against the buses too
    always_comb begin
        a_next = fill_i ? wake(src_a_rdy_i, src_a_tag_i, src_a_i) : wake(a_rdy_q, a_tag_q, opa_q);
        b_next = fill_i ? wake(src_b_rdy_i, src_b_tag_i, src_b_i) : wake(b_rdy_q, b_tag_q, opb_q);
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i || clear_i) begin
            busy_q <= 1'b0;
        end else if (fill_i) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            op_q    <= op_i;
            tag_q   <= tag_i;
            a_tag_q <= src_a_tag_i;
            b_tag_q <= src_b_tag_i;
        end
        if (fill_i || busy_q) begin
            {a_rdy_q, opa_q} <= a_next;
            {b_rdy_q, opb_q} <= b_next;
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q & a_rdy_q & b_rdy_q;
    assign op_o    = op_q;
    assign tag_o   = tag_q;
    assign opa_o   = opa_q;
    assign opb_o   = opb_q;

endmodule

`default_nettype wire

// File: rtl/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // operand, result and ROB tag widths
    localparam int XLEN  = 32;
    localparam int TAG_W = 4;

    // APB side of the CSR block
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // ----------------------------------------------------------------------
    // integer ALU opcodes
    // ----------------------------------------------------------------------
    // shifts take the low 5 bits of operand b
    // slt is a signed compare, result is 1 or 0
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // ----------------------------------------------------------------------
    // CSR byte addresses
    // ----------------------------------------------------------------------
    // bit 0 issue enable, bit 1 flush command
    localparam logic [APB_AW-1:0] CSR_CTRL   = 8'h00;
    // queue occupancy, read only
    localparam logic [APB_AW-1:0] CSR_STATUS = 8'h04;
    // issued instruction count
    localparam logic [APB_AW-1:0] CSR_ISSUED = 8'h08;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for failures
rm -f sim.log
verilator --binary --timing --assert --top-module alu_issue_tb -f vlog.f -o alu_issue_sim \
    && ./obj_dir/alu_issue_sim > sim.log 2>&1 \
    || echo "simulation did not complete" >> sim.log
cat sim.log
! grep -q -e "Test failures found" -e "%Error" -e "did not complete" sim.log

// File: verif/alu_issue_properties.sv
`default_nettype none

module alu_issue_properties #(
    parameter int IQ_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          flush_i,
    input  logic                          dispatch_ready_o,
    input  logic                          result_valid_o,
    input  logic                          result_ready_i,
    input  logic [iq_pkg::TAG_W-1:0]      result_tag_o,
    input  logic [iq_pkg::XLEN-1:0]       result_data_o,
    input  logic [$clog2(IQ_SIZE+1)-1:0]  occupancy_o
);

    localparam int               OCC_W = $clog2(IQ_SIZE + 1);
    localparam logic [OCC_W-1:0] FULL  = OCC_W'(IQ_SIZE);

    // stalled result keeps valid, tag and data until it drains
    result_held: assert property (@(posedge clk) disable iff (rst_i)
        result_valid_o && !result_ready_i && !flush_i
        |=> result_valid_o && $stable(result_tag_o) && $stable(result_data_o))
        else $error("result changed while stalled");

    occupancy_bound: assert property (@(posedge clk) disable iff (rst_i)
        occupancy_o <= FULL)
        else $error("occupancy above queue size");

    // ready drops only on a full queue
    ready_vs_full: assert property (@(posedge clk) disable iff (rst_i)
        dispatch_ready_o == (occupancy_o != FULL))
        else $error("dispatch ready disagrees with occupancy");

endmodule

bind alu_issue_queue alu_issue_properties #(.IQ_SIZE(IQ_SIZE)) u_properties (
    .clk(clk), .rst_i(rst_i), .flush_i(flush_i), .dispatch_ready_o(dispatch_ready_o),
    .result_valid_o(result_valid_o), .result_ready_i(result_ready_i),
    .result_tag_o(result_tag_o), .result_data_o(result_data_o), .occupancy_o(occupancy_o)
);

`default_nettype wire

// File: verif/alu_issue_tb.sv
`default_nettype none

module alu_issue_tb;
    import iq_pkg::*;

    localparam int IQ_SIZE    = 4;
    localparam int WAIT_LIMIT = 200;

    logic              clk;
    logic              rst_i;
    logic              dispatch_valid_i;
    alu_op_e           dispatch_op_i;
    logic [TAG_W-1:0]  dispatch_tag_i;
    logic [XLEN-1:0]   src_a_i;
    logic [XLEN-1:0]   src_b_i;
    logic              src_a_rdy_i;
    logic              src_b_rdy_i;
    logic [TAG_W-1:0]  src_a_tag_i;
    logic [TAG_W-1:0]  src_b_tag_i;
    logic              dispatch_ready_o;
    logic              cdb_valid_i;
    logic [TAG_W-1:0]  cdb_tag_i;
    logic [XLEN-1:0]   cdb_data_i;
    logic              result_valid_o;
    logic [TAG_W-1:0]  result_tag_o;
    logic [XLEN-1:0]   result_data_o;
    logic              result_ready_i;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [APB_DW-1:0] pwdata_i;
    logic [APB_DW-1:0] prdata_o;

    // scoreboard, indexed by result tag
    logic [XLEN-1:0]   exp_data [2**TAG_W];
    logic              exp_live [2**TAG_W];
    int                pending;
    int                results_seen;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                test_errs_start;
    string             test_name;
    integer            seed;

    logic [APB_DW-1:0] rd;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   ext;
    logic [XLEN-1:0]   r1;
    alu_op_e           op;
    int                stall;
    int                seen_start;

    alu_issue_top #(.IQ_SIZE(IQ_SIZE), .AGE_BITS(3)) UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // reference results from the opcode rules
    function automatic logic [XLEN-1:0] model_result(input alu_op_e op_in,
                                                     input logic [XLEN-1:0] x,
                                                     input logic [XLEN-1:0] y);
        logic [4:0] sh;
        sh = y[4:0];
        case (op_in)
            ALU_ADD: return x + y;
            ALU_SUB: return x + ~y + 32'd1;
            ALU_AND: return x & y;
            ALU_OR:  return x | y;
            ALU_XOR: return x ^ y;
            ALU_SLL: return x << sh;
            ALU_SRL: return x >> sh;
            ALU_SLT: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (expected == actual) else begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        test_errs_start = errors;
    endtask

    task automatic end_test();
        tests_run = tests_run + 1;
        if (errors != test_errs_start) begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAILED with %0d errors", test_name, errors - test_errs_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    // ------------------------------------------------------------------
    // APB, CDB and dispatch drivers
    // ------------------------------------------------------------------
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        next_cycle();
        penable_i = 1'b1;
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        next_cycle();
        penable_i = 1'b1;
        @(negedge clk);
        data = prdata_o;
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic cdb_broadcast(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = tag;
        cdb_data_i  = data;
        next_cycle();
        cdb_valid_i = 1'b0;
    endtask

    // operand b is always ready, operand a may wait on a_tag
    task automatic dispatch(input alu_op_e op_in, input logic [TAG_W-1:0] tag,
                            input logic [XLEN-1:0] x, input logic [XLEN-1:0] y,
                            input logic a_pending, input logic [TAG_W-1:0] a_tag,
                            input logic [XLEN-1:0] expected);
        int   waited;
        logic taken;
        waited           = 0;
        taken            = 1'b0;
        exp_data[tag]    = expected;
        exp_live[tag]    = 1'b1;
        pending          = pending + 1;
        dispatch_valid_i = 1'b1;
        dispatch_op_i    = op_in;
        dispatch_tag_i   = tag;
        src_a_i          = x;
        src_b_i          = y;
        src_a_rdy_i      = ~a_pending;
        src_a_tag_i      = a_tag;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = dispatch_ready_o;
            next_cycle();
            waited = waited + 1;
        end
        dispatch_valid_i = 1'b0;
        if (!taken) begin
            $display("test %s: dispatch of tag %0d was never accepted", test_name, tag);
            errors        = errors + 1;
            exp_live[tag] = 1'b0;
            pending       = pending - 1;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited = waited + 1;
        end
        if (pending != 0) begin
            $display("test %s: %0d results never arrived", test_name, pending);
            errors = errors + 1;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        int seen_before;
        seen_before = results_seen;
        repeat (cycles) next_cycle();
        assert (results_seen == seen_before) else begin
            $display("test %s: a result appeared while none was expected", test_name);
            errors = errors + 1;
        end
    endtask

    // result monitor, a transfer is seen between edges
    always @(negedge clk) begin
        if (!rst_i && result_valid_o && result_ready_i) begin
            results_seen = results_seen + 1;
            assert (exp_live[result_tag_o]) else begin
                $display("test %s: result for tag %0d was not expected", test_name,
                         result_tag_o);
                errors = errors + 1;
            end
            if (exp_live[result_tag_o]) begin
                check_value($sformatf("tag %0d data", result_tag_o), exp_data[result_tag_o],
                            result_data_o);
                exp_live[result_tag_o] = 1'b0;
                pending = pending - 1;
            end
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        seed             = 49205;
        pending          = 0;
        results_seen     = 0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        test_errs_start  = 0;
        test_name        = "init";
        for (int i = 0; i < 2**TAG_W; i++) begin
            exp_live[i] = 1'b0;
            exp_data[i] = '0;
        end
        rst_i            = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_op_i    = ALU_ADD;
        dispatch_tag_i   = '0;
        src_a_i          = '0;
        src_b_i          = '0;
        src_a_rdy_i      = 1'b1;
        src_b_rdy_i      = 1'b1;
        src_a_tag_i      = '0;
        src_b_tag_i      = '0;
        cdb_valid_i      = 1'b0;
        cdb_tag_i        = '0;
        cdb_data_i       = '0;
        result_ready_i   = 1'b1;
        psel_i           = 1'b0;
        penable_i        = 1'b0;
        pwrite_i         = 1'b0;
        paddr_i          = '0;
        pwdata_i         = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;

        begin_test("reset");
        check_value("dispatch ready", 32'd1, XLEN'(dispatch_ready_o));
        check_value("result valid", 32'd0, XLEN'(result_valid_o));
        apb_read(CSR_CTRL, rd);
        check_value("CTRL", 32'd0, rd);
        end_test();

        begin_test("all opcodes");
        apb_write(CSR_CTRL, 32'h1);
        for (int i = 0; i < 8; i++) begin
            op = alu_op_e'(i);
            a  = $random(seed);
            b  = $random(seed);
            dispatch(op, TAG_W'(i), a, b, 1'b0, '0, model_result(op, a, b));
        end
        wait_drained();
        end_test();

        begin_test("full queue");
        apb_write(CSR_CTRL, 32'h0);
        apb_write(CSR_ISSUED, 32'h0);
        for (int i = 0; i < 4; i++) begin
            op = alu_op_e'(7 - i);
            a  = $random(seed);
            b  = $random(seed);
            dispatch(op, TAG_W'(8 + i), a, b, 1'b0, '0, model_result(op, a, b));
        end
        check_value("dispatch ready", 32'd0, XLEN'(dispatch_ready_o));
        apb_read(CSR_STATUS, rd);
        check_value("STATUS", 32'd4, rd);
        apb_write(CSR_CTRL, 32'h1);
        wait_drained();
        apb_read(CSR_ISSUED, rd);
        check_value("ISSUED", 32'd4, rd);
        end_test();

        begin_test("cdb wakeup");
        ext = $random(seed);
        b   = $random(seed);
        dispatch(ALU_ADD, 4'd2, 32'd0, b, 1'b1, 4'hc, model_result(ALU_ADD, ext, b));
        expect_quiet(6);
        cdb_broadcast(4'hc, ext);
        wait_drained();
        end_test();

        begin_test("result forwarding");
        result_ready_i = 1'b0;
        a  = $random(seed);
        b  = $random(seed);
        r1 = model_result(ALU_SUB, a, b);
        dispatch(ALU_SUB, 4'd3, a, b, 1'b0, '0, r1);
        b = $random(seed);
        dispatch(ALU_XOR, 4'd4, 32'd0, b, 1'b1, 4'd3, model_result(ALU_XOR, r1, b));
        result_ready_i = 1'b1;
        wait_drained();
        end_test();

        begin_test("back-pressure");
        seen_start     = results_seen;
        result_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            op = alu_op_e'($random(seed) & 7);
            a  = $random(seed);
            b  = $random(seed);
            dispatch(op, TAG_W'(5 + i), a, b, 1'b0, '0, model_result(op, a, b));
        end
        stall = 2 + ($random(seed) & 7);
        repeat (stall) next_cycle();
        check_value("held valid", 32'd1, XLEN'(result_valid_o));
        check_value("held tag", 32'd5, XLEN'(result_tag_o));
        result_ready_i = 1'b1;
        wait_drained();
        check_value("result count", 32'd3, XLEN'(results_seen - seen_start));
        end_test();

        begin_test("flush");
        // first result parks in the output stage and the rest stay queued
        result_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            a = $random(seed);
            b = $random(seed);
            dispatch(ALU_OR, TAG_W'(12 + i), a, b, 1'b0, '0, model_result(ALU_OR, a, b));
        end
        // flushed tags must never come back
        for (int i = 12; i < 15; i++) begin
            exp_live[i] = 1'b0;
        end
        pending = pending - 3;
        apb_write(CSR_CTRL, 32'h2);
        apb_read(CSR_STATUS, rd);
        check_value("STATUS", 32'd0, rd);
        check_value("dispatch ready", 32'd1, XLEN'(dispatch_ready_o));
        check_value("result valid", 32'd0, XLEN'(result_valid_o));
        result_ready_i = 1'b1;
        apb_write(CSR_CTRL, 32'h1);
        expect_quiet(8);
        end_test();

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/iq_pkg.sv
rtl/int_alu.sv
rtl/iq_entry.sv
rtl/iq_age_select.sv
rtl/alu_issue_queue.sv
rtl/iq_csr_apb.sv
rtl/alu_issue_top.sv
verif/alu_issue_properties.sv
verif/alu_issue_tb.sv
